// File: Makefile
# Verilator simulation of the I/O page peripherals

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f iopage_periph.f \
		--top-module tb_iopage --Mdir obj_dir -o sim_iopage
	./obj_dir/sim_iopage | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: iopage_periph.f
rtl/iopage_pkg.sv
rtl/line_tick_gen.sv
rtl/kw11l_clock_fsm.sv
rtl/console_swr.sv
rtl/iopage_decode.sv
rtl/iopage_periph.sv
testbench/tb_iopage.sv

// File: rtl/console_swr.sv
//******************************
// console switch register (read)
// and display register (write)
//******************************

`timescale 1ns/1ps
`default_nettype none

module console_swr (
   input  logic               clk_p,          // board clock
   input  logic               rst_n_i,        // async reset, active low
   input  logic               wr_i,           // display write strobe
   input  iopage_pkg::word_t  wdat_i,         // write data from the bus
   input  iopage_pkg::word_t  csw_i,          // console switches
   output iopage_pkg::word_t  rdat_o,         // read data
   output iopage_pkg::word_t  swr_o           // display lamps
);

   import iopage_pkg::*;

   word_t disp_q;                             // display register

   always_ff @(posedge clk_p or negedge rst_n_i) begin
      if (!rst_n_i) begin
         disp_q <= '0;                        // lamps dark after reset
      end else if (wr_i) begin
         disp_q <= wdat_i;                    // load display
      end
   end

   assign rdat_o = csw_i;                     // reads see the switches
   assign swr_o  = disp_q;

endmodule : console_swr

`default_nettype wire

// File: rtl/iopage_decode.sv
//******************************
// I/O page address decode, read mux,
// one-shot acknowledge and vector select
//******************************

`timescale 1ns/1ps
`default_nettype none

module iopage_decode (
   input  logic                  clk_p,       // board clock
   input  logic                  rst_n_i,     // async reset, active low
   input  iopage_pkg::bus_req_t  req_i,       // bus request from the cpu
   input  iopage_pkg::word_t     swr_dat_i,   // console read data
   input  iopage_pkg::word_t     kw11l_dat_i, // line clock csr
   input  logic                  istb6_i,     // level-6 vector strobe
   input  iopage_pkg::vec_t      ivec_i,      // external vector
   output logic                  swr_wr_o,    // display write strobe
   output logic                  kw11l_wr_o,  // csr write strobe
   output iopage_pkg::bus_rsp_t  rsp_o,       // bus response
   output iopage_pkg::vec_t      vector_o     // vector to the cpu
);

   import iopage_pkg::*;

   logic  swr_sel;                            // 177570 selected
   logic  kw11l_sel;                          // 177546 selected
   logic  any_sel;                            // some local device hit
   logic  ack_set;                            // cycle that issues ack
   logic  ack_q;                              // registered ack
   word_t rd_mux;                             // read data

   //******************************
   // address compare
   //******************************
   // word compare, bit 0 ignored
   assign swr_sel   = req_i.stb && (req_i.adr[15:1] == SWR_ADR[15:1]);
   assign kw11l_sel = req_i.stb && (req_i.adr[15:1] == KW11L_ADR[15:1]);
   assign any_sel   = swr_sel | kw11l_sel;

   //******************************
   // acknowledge
   //******************************
   assign ack_set = any_sel & ~ack_q;         // first cycle of a decoded strobe

   always_ff @(posedge clk_p or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= ack_set;                    // one pulse, then low
      end
   end

   // writes land on the same edge as ack
   assign swr_wr_o   = ack_set & swr_sel & req_i.we;
   assign kw11l_wr_o = ack_set & kw11l_sel & req_i.we;

   //******************************
   // read data
   //******************************
   always_comb begin
      rd_mux = '0;
      if (swr_sel) begin
         rd_mux = rd_mux | swr_dat_i;
      end
      if (kw11l_sel) begin
         rd_mux = rd_mux | kw11l_dat_i;
      end
   end

   assign rsp_o.dat = rd_mux;
   assign rsp_o.ack = ack_q;

   // timer owns level 6, the rest comes from outside
   assign vector_o = istb6_i ? KW11L_VEC : ivec_i;

   // a held strobe must not produce back-to-back replies
   a_ack_one_shot: assert property (@(posedge clk_p) disable iff (!rst_n_i)
      rsp_o.ack |=> !rsp_o.ack)
      else $error("bus ack high for two consecutive cycles");

endmodule : iopage_decode

`default_nettype wire

// File: rtl/iopage_periph.sv
//******************************
// I/O page peripherals, top level
// console register, KW11-L clock,
// decode and vector select
//******************************

`timescale 1ns/1ps
`default_nettype none

module iopage_periph #(
   parameter int tick_div = iopage_pkg::TICK_DIV_DEFAULT   // clocks per line tick
) (
   input  logic                  clk_p,       // board clock
   input  logic                  rst_n_i,     // async reset, active low
   input  iopage_pkg::bus_req_t  bus_req_i,   // bus request
   output iopage_pkg::bus_rsp_t  bus_rsp_o,   // bus response
   input  iopage_pkg::word_t     csw_i,       // console switches
   output iopage_pkg::word_t     swr_o,       // console display
   input  logic                  istb6_i,     // level-6 vector strobe
   input  iopage_pkg::vec_t      ivec_i,      // external vector
   output iopage_pkg::vec_t      vector_o,    // vector to the cpu
   output logic                  timer_irq_o, // level-6 request
   output logic                  led_timer_o  // timer enabled
);

   import iopage_pkg::*;

   logic  tick;                               // line tick strobe
   logic  swr_wr;                             // display write
   logic  kw11l_wr;                           // csr write
   word_t swr_rdat;                           // switch read data
   word_t kw11l_csr;                          // csr read data

   //******************************
   // line clock
   //******************************
   line_tick_gen #(
      .tick_div (tick_div)
   ) u_tick (
      .clk_p    (clk_p),
      .rst_n_i  (rst_n_i),
      .tick_o   (tick)
   );

   kw11l_clock_fsm u_kw11l (
      .clk_p       (clk_p),
      .rst_n_i     (rst_n_i),
      .tick_i      (tick),
      .istb6_i     (istb6_i),                 // clears the request
      .wr_i        (kw11l_wr),
      .wdat_i      (bus_req_i.dat),
      .csr_o       (kw11l_csr),
      .timer_irq_o (timer_irq_o),
      .ie_o        (led_timer_o)              // enable drives the led
   );

   //******************************
   // console and bus glue
   //******************************
   console_swr u_swr (
      .clk_p   (clk_p),
      .rst_n_i (rst_n_i),
      .wr_i    (swr_wr),
      .wdat_i  (bus_req_i.dat),
      .csw_i   (csw_i),
      .rdat_o  (swr_rdat),
      .swr_o   (swr_o)
   );

   iopage_decode u_decode (
      .clk_p       (clk_p),
      .rst_n_i     (rst_n_i),
      .req_i       (bus_req_i),
      .swr_dat_i   (swr_rdat),
      .kw11l_dat_i (kw11l_csr),
      .istb6_i     (istb6_i),                 // picks the timer vector
      .ivec_i      (ivec_i),
      .swr_wr_o    (swr_wr),
      .kw11l_wr_o  (kw11l_wr),
      .rsp_o       (bus_rsp_o),
      .vector_o    (vector_o)
   );

endmodule : iopage_periph

`default_nettype wire

// File: rtl/iopage_pkg.sv
//******************************
// shared types and constants for the local I/O page
// bus request/response structs, device addresses,
// KW11-L bit positions, vector and clock rates
//******************************

`default_nettype none

package iopage_pkg;

   //******************************
   // basic widths
   //******************************
   typedef logic [15:0] word_t;              // bus data word
   typedef logic [15:0] iopage_adr_t;        // low 16 bits of the byte address
   typedef logic [8:0]  vec_t;               // interrupt vector address

   // cpu -> peripherals
   typedef struct packed {
      iopage_adr_t adr;                      // byte address
      word_t       dat;                      // write data
      logic        we;                       // 1 = write cycle
      logic        stb;                      // held until ack
   } bus_req_t;

   // peripherals -> cpu
   typedef struct packed {
      word_t dat;                            // read data, zero when not selected
      logic  ack;                            // one-cycle reply
   } bus_rsp_t;

   //******************************
   // device map
   //******************************
   localparam iopage_adr_t SWR_ADR   = 16'o177570;   // console switch/display
   localparam iopage_adr_t KW11L_ADR = 16'o177546;   // line clock csr

   // KW11-L csr layout
   localparam int KW11L_RDY_BIT = 7;        // ready, set by each line tick
   localparam int KW11L_IE_BIT  = 6;        // interrupt enable

   localparam vec_t KW11L_VEC = 9'o100;     // level-6 timer vector

   //******************************
   // line clock rate
   //******************************
   localparam int CLK_REF_HZ = 50_000_000;  // board clock
   localparam int LINE_HZ    = 50;          // mains frequency
   localparam int TICK_DIV_DEFAULT = CLK_REF_HZ / LINE_HZ;

endpackage : iopage_pkg

`default_nettype wire

// File: rtl/kw11l_clock_fsm.sv
//******************************
// KW11-L line clock status register
// ready/enable bits and level-6 request FSM
//******************************

`timescale 1ns/1ps
`default_nettype none

module kw11l_clock_fsm (
   input  logic               clk_p,          // board clock
   input  logic               rst_n_i,        // async reset, active low
   input  logic               tick_i,         // line tick strobe
   input  logic               istb6_i,        // cpu fetches level-6 vector
   input  logic               wr_i,           // csr write strobe
   input  iopage_pkg::word_t  wdat_i,         // csr write data
   output iopage_pkg::word_t  csr_o,          // csr read value
   output logic               timer_irq_o,    // level-6 request
   output logic               ie_o            // enable bit, for the led
);

   import iopage_pkg::*;

   typedef enum logic {
      IDLE,                                   // no request
      PENDING                                 // request raised, waiting for vector
   } kw11l_state_t;

   kw11l_state_t state_q;
   kw11l_state_t state_d;

   logic ie_q;                                // interrupt enable
   logic rdy_q;                               // ready flag

   //******************************
   // csr bits
   //******************************
   always_ff @(posedge clk_p or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ie_q  <= 1'b0;
         rdy_q <= 1'b1;                       // ready after reset
      end else begin
         if (wr_i) begin
            ie_q  <= wdat_i[KW11L_IE_BIT];    // load from bus
            rdy_q <= wdat_i[KW11L_RDY_BIT];
         end
         if (tick_i) begin
            rdy_q <= 1'b1;                    // tick wins over a write
         end
      end
   end

   //******************************
   // request FSM
   //******************************
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (tick_i && ie_q) begin
               state_d = PENDING;             // raise the request
            end
         end
         PENDING: begin
            if (istb6_i || !ie_q) begin
               state_d = IDLE;                // vector taken or irq disabled
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_p or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // read view: ready in 7, enable in 6
   always_comb begin
      csr_o                = '0;
      csr_o[KW11L_RDY_BIT] = rdy_q;
      csr_o[KW11L_IE_BIT]  = ie_q;
   end

   assign timer_irq_o = (state_q == PENDING);
   assign ie_o        = ie_q;

   // a disabled clock must drop its request within one cycle
   a_irq_follows_ie: assert property (@(posedge clk_p) disable iff (!rst_n_i)
      !ie_q ##1 !ie_q |-> state_q == IDLE)
      else $error("timer request still pending with enable low");

endmodule : kw11l_clock_fsm

`default_nettype wire

// File: rtl/line_tick_gen.sv
//******************************
// line-frequency tick generator
// one-cycle strobe every tick_div clocks
//******************************

`timescale 1ns/1ps
`default_nettype none

module line_tick_gen #(
   parameter int tick_div = 1000              // clocks per tick
) (
   input  logic clk_p,                        // board clock
   input  logic rst_n_i,                      // async reset, active low
   output logic tick_o                        // single-cycle tick
);

   localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;   // counter width
   localparam logic [cnt_w-1:0] cnt_last = cnt_w'(tick_div - 1);   // wrap value

   logic [cnt_w-1:0] cnt_q;                   // cycle counter

   always_ff @(posedge clk_p or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q  <= '0;
         tick_o <= 1'b0;
      end else if (cnt_q == cnt_last) begin
         cnt_q  <= '0;                        // wrap
         tick_o <= 1'b1;                      // fire the tick
      end else begin
         cnt_q  <= cnt_q + cnt_w'(1);         // count clocks
         tick_o <= 1'b0;                      // end of pulse
      end
   end

   // the tick is a strobe, never a level
   a_tick_single: assert property (@(posedge clk_p) disable iff (!rst_n_i)
      tick_o |=> !tick_o)
      else $error("line tick held high for two cycles");

endmodule : line_tick_gen

`default_nettype wire

// File: testbench/iopage_trace.txt
# columns: opcode then arguments; addresses and data octal, wait cycles and irq level decimal
# write adr dat | read adr expected | wait cycles | irq level | vec istb6 ivec expected | csw value

# console switches and display
csw   012345
read  177570 012345
write 177570 052525

# line clock csr after reset and after writes
read  177546 000200
write 177546 000100
read  177546 000100
write 177546 000000
read  177546 000000
irq   0

# a tick sets ready with enable off, no request
wait  50
irq   0
wait  60
irq   0
read  177546 000200

# enabled clock raises a level-6 request
write 177546 000100
read  177546 000100
irq   0
wait  110
irq   1
read  177546 000300
vec   1 000 100
irq   0
vec   0 234 234
vec   0 777 777
vec   1 234 100

# clearing enable withdraws the request
wait  50
irq   1
write 177546 000000
irq   0
read  177546 000000

# unmapped word gets no reply
read  177560 000000

# odd byte address hits the same word
csw   170017
read  177570 170017
write 177571 000377
read  177547 000000
wait  20
irq   0

// File: testbench/tb_iopage.sv
//******************************
// testbench for the I/O page peripherals
// trace reader, bus cycle task, checks
// and a cycle-count timeout
//******************************

`timescale 1ns/1ps
`default_nettype none

module tb_iopage;

   import iopage_pkg::*;

   localparam logic [15:0] console_adr   = 16'o177570;   // switch/display word
   localparam logic [15:0] clock_csr_adr = 16'o177546;   // KW11-L csr word
   localparam int ack_window = 4;                        // cycles allowed for ack

   // trace opcodes
   localparam int op_csw   = 0;
   localparam int op_write = 1;
   localparam int op_read  = 2;
   localparam int op_wait  = 3;
   localparam int op_irq   = 4;
   localparam int op_vec   = 5;

   // trace tokens, right-justified like %s fills them
   localparam logic [63:0] tok_comment = {56'd0, "#"};
   localparam logic [63:0] tok_csw     = {40'd0, "csw"};
   localparam logic [63:0] tok_write   = {24'd0, "write"};
   localparam logic [63:0] tok_read    = {32'd0, "read"};
   localparam logic [63:0] tok_wait    = {32'd0, "wait"};
   localparam logic [63:0] tok_irq     = {40'd0, "irq"};
   localparam logic [63:0] tok_vec     = {40'd0, "vec"};

   logic     clk_p;
   logic     rst_n;
   bus_req_t bus_req;                         // master side of the bus
   bus_rsp_t bus_rsp;
   word_t    csw;                             // console switches
   word_t    swr;                             // display lamps
   logic     istb6;
   vec_t     ivec;
   vec_t     vector;
   logic     timer_irq;
   logic     led_timer;

   int op_kind[$];                            // parsed trace
   int op_a[$];
   int op_b[$];
   int op_c[$];
   int wait_sum    = 0;                       // total wait cycles in the trace
   int bus_ops     = 0;                       // reads and writes in the trace
   int err_count   = 0;
   int check_count = 0;
   int cycle_count = 0;
   int cycle_limit = 0;                       // zero until the trace is read

   iopage_periph #(
      .tick_div (100)                         // short line period for simulation
   ) UUT (
      .clk_p       (clk_p),
      .rst_n_i     (rst_n),
      .bus_req_i   (bus_req),
      .bus_rsp_o   (bus_rsp),
      .csw_i       (csw),
      .swr_o       (swr),
      .istb6_i     (istb6),
      .ivec_i      (ivec),
      .vector_o    (vector),
      .timer_irq_o (timer_irq),
      .led_timer_o (led_timer)
   );

   always #10 clk_p = ~clk_p;                 // 20 ns period

   //******************************
   // timeout
   //******************************
   always @(posedge clk_p) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, the trace did not finish", cycle_count);
         $display("tests failed");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input logic [15:0] expected,
                                  input logic [15:0] got);
      $display("FAIL at %0t ns: %s expected %o got %o", $time, name, expected, got);
      err_count++;
   endtask

   function automatic logic is_mapped(input logic [15:0] adr);
      return (adr[15:1] == console_adr[15:1]) || (adr[15:1] == clock_csr_adr[15:1]);
   endfunction

   // store one trace operation if its argument count is right
   task automatic add_op(input int kind, input int want, input int got,
                         input int a, input int b, input int c);
      if (got != want) begin
         $display("malformed trace line, operation %0d has %0d of %0d arguments",
                  kind, got, want);
         err_count++;
      end else begin
         op_kind.push_back(kind);
         op_a.push_back(a);
         op_b.push_back(b);
         op_c.push_back(c);
         if (kind == op_wait) begin
            wait_sum += a;
         end
         if (kind == op_write || kind == op_read) begin
            bus_ops++;
         end
      end
   endtask

   //******************************
   // trace reader
   //******************************
   task automatic load_trace();
      int          fd;
      int          n;
      int          ch;
      int          a;
      int          b;
      int          c;
      logic [63:0] op_word;
      logic        done;
      fd = $fopen("testbench/iopage_trace.txt", "r");
      if (fd == 0) begin
         $display("the trace file testbench/iopage_trace.txt could not be opened");
         err_count++;
      end else begin
         done = 1'b0;
         while (!done) begin
            op_word = '0;
            a = 0;
            b = 0;
            c = 0;
            n = $fscanf(fd, "%s", op_word);
            if (n != 1) begin
               done = 1'b1;                   // end of file
            end else begin
               case (op_word)
                  tok_comment: begin
                     ch = 0;
                     while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);      // skip to end of line
                     end
                  end
                  tok_csw: begin
                     n = $fscanf(fd, "%o", a);
                     add_op(op_csw, 1, n, a, b, c);
                  end
                  tok_write: begin
                     n = $fscanf(fd, "%o %o", a, b);
                     add_op(op_write, 2, n, a, b, c);
                  end
                  tok_read: begin
                     n = $fscanf(fd, "%o %o", a, b);
                     add_op(op_read, 2, n, a, b, c);
                  end
                  tok_wait: begin
                     n = $fscanf(fd, "%d", a);   // decimal cycles
                     add_op(op_wait, 1, n, a, b, c);
                  end
                  tok_irq: begin
                     n = $fscanf(fd, "%d", a);
                     add_op(op_irq, 1, n, a, b, c);
                  end
                  tok_vec: begin
                     n = $fscanf(fd, "%d %o %o", a, b, c);
                     add_op(op_vec, 3, n, a, b, c);
                  end
                  default: begin
                     $display("unknown operation in the trace file");
                     err_count++;
                     done = 1'b1;
                  end
               endcase
            end
         end
         $fclose(fd);
      end
   endtask

   // one bus cycle, stb held until ack or until the window runs out
   task automatic bus_cycle(input logic we, input logic [15:0] adr,
                            input logic [15:0] wdat, output logic got_ack,
                            output logic [15:0] rdat, output logic [15:0] dat_or);
      int n;
      got_ack = 1'b0;
      rdat    = '0;
      dat_or  = '0;
      n       = 0;
      @(posedge clk_p);
      bus_req.adr <= adr;
      bus_req.dat <= wdat;
      bus_req.we  <= we;
      bus_req.stb <= 1'b1;
      while (!got_ack && n < ack_window) begin
         @(negedge clk_p);                    // outputs settled here
         if (bus_rsp.ack) begin
            got_ack = 1'b1;
            rdat    = bus_rsp.dat;
         end else begin
            dat_or = dat_or | bus_rsp.dat;    // any data without ack
         end
         n++;
      end
      @(posedge clk_p);
      bus_req <= '0;                          // drop stb the cycle after ack
      @(negedge clk_p);
   endtask

   //******************************
   // one trace operation
   //******************************
   task automatic run_op(input int kind, input int a, input int b, input int c);
      logic        got_ack;
      logic [15:0] rdat;
      logic [15:0] dat_or;
      case (kind)
         op_csw: begin
            @(posedge clk_p);
            csw <= a[15:0];
            @(negedge clk_p);
         end
         op_write: begin
            check_count++;
            bus_cycle(1'b1, a[15:0], b[15:0], got_ack, rdat, dat_or);
            if (!got_ack) begin
               $display("no ack within %0d cycles for the write to %o", ack_window, a[15:0]);
               err_count++;
            end else if (a[15:1] == console_adr[15:1]) begin
               if (swr !== b[15:0]) begin
                  report_mismatch("swr_o", b[15:0], swr);
               end
            end else if (a[15:1] == clock_csr_adr[15:1]) begin
               if (led_timer !== b[6]) begin  // enable bit shows on the led
                  report_mismatch("led_timer_o", {15'd0, b[6]}, {15'd0, led_timer});
               end
            end
         end
         op_read: begin
            check_count++;
            bus_cycle(1'b0, a[15:0], 16'h0000, got_ack, rdat, dat_or);
            if (is_mapped(a[15:0])) begin
               if (!got_ack) begin
                  $display("no ack within %0d cycles for the read of %o", ack_window, a[15:0]);
                  err_count++;
               end else if (rdat !== b[15:0]) begin
                  report_mismatch("bus_rsp_o.dat", b[15:0], rdat);
               end
            end else begin
               if (got_ack) begin
                  $display("the unmapped address %o was acknowledged", a[15:0]);
                  err_count++;
               end
               if (dat_or !== 16'h0000) begin
                  report_mismatch("bus_rsp_o.dat", 16'h0000, dat_or);
               end
            end
         end
         op_wait: begin
            repeat (a) @(posedge clk_p);
            @(negedge clk_p);
         end
         op_irq: begin
            check_count++;
            if (timer_irq !== a[0]) begin
               report_mismatch("timer_irq_o", {15'd0, a[0]}, {15'd0, timer_irq});
            end
         end
         op_vec: begin
            check_count++;
            @(posedge clk_p);
            istb6 <= a[0];
            ivec  <= b[8:0];
            @(negedge clk_p);
            if (vector !== c[8:0]) begin
               report_mismatch("vector_o", {7'd0, c[8:0]}, {7'd0, vector});
            end
            @(posedge clk_p);
            istb6 <= 1'b0;                    // strobe lasts one cycle
            ivec  <= '0;
            @(negedge clk_p);
         end
         default: begin
            $display("operation %0d cannot be run", kind);
            err_count++;
         end
      endcase
   endtask

   //******************************
   // main sequence
   //******************************
   initial begin
      clk_p   = 1'b0;
      rst_n   = 1'b0;
      bus_req = '0;
      csw     = '0;
      istb6   = 1'b0;
      ivec    = '0;
      load_trace();
      if (err_count == 0 && op_kind.size() == 0) begin
         $display("the trace file holds no operations");
         err_count++;
      end
      cycle_limit = wait_sum + 10 * bus_ops + 200;
      repeat (4) @(posedge clk_p);            // reset for 4 cycles
      rst_n <= 1'b1;
      @(negedge clk_p);
      if (err_count == 0) begin
         for (int i = 0; i < op_kind.size(); i++) begin
            run_op(op_kind[i], op_a[i], op_b[i], op_c[i]);
         end
      end
      $display("%0d operations, %0d checks, %0d errors",
               op_kind.size(), check_count, err_count);
      if (err_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule : tb_iopage

`default_nettype wire
